//--- design/cache_pkg.sv
// ---------------------------------------
// cache package
// shared widths, address fields and the
// cache, tag and burst bus structs
// ---------------------------------------

`default_nettype none

package cache_pkg;

  // processor and burst RAM widths
  localparam int WORD_BITS = 32;
  localparam int BEAT_BITS = 64;

  // address split: |line address|col|offset|
  localparam int OFFSET_BITS = 2;
  localparam int COL_BITS = 3;
  localparam int COLS = 1 << COL_BITS;
  localparam int BEATS = COLS * WORD_BITS / BEAT_BITS;
  localparam int LINE_ADDR_BITS = WORD_BITS - OFFSET_BITS - COL_BITS;
  // burst RAM addresses count 64-bit beats
  localparam int BEAT_ADDR_BITS = LINE_ADDR_BITS + $clog2(BEATS);

  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [WORD_BITS/8-1:0] strobe_t;
  typedef logic [BEAT_BITS-1:0] beat_t;

  // word 0 sits in the low bits, beat k holds words 2k and 2k+1
  typedef logic [COLS-1:0][WORD_BITS-1:0] line_t;

  // full line address kept, so tag width is independent of line count
  typedef struct packed {
    logic valid;
    logic dirty;
    logic [LINE_ADDR_BITS-1:0] line_addr;
  } tag_entry_t;

  // a request with any strobe bit set is a write
  typedef struct packed {
    word_t addr;
    word_t wdata;
    strobe_t strobe;
  } cpu_req_t;

  typedef struct packed {
    logic cmd_en;
    logic write;
    logic [BEAT_ADDR_BITS-1:0] addr;
    beat_t wdata;
  } br_req_t;

  typedef struct packed {
    beat_t rdata;
    logic rd_data_ready;
    logic busy;
  } br_rsp_t;

endpackage

`default_nettype wire

//--- design/cache_ram.sv
// ---------------------------------------
// cache storage array
// line-indexed, clocked write, async read
// cleared by a sweep after reset
// ---------------------------------------

`timescale 1ns/1ps
`default_nettype none

module cache_ram #(
  parameter int LINE_IX_BITS = 8,
  parameter type entry_t = logic
) (
  input wire clk,
  input wire rst,
  input wire [LINE_IX_BITS-1:0] index,
  input wire we,
  input wire entry_t wdata,
  output entry_t rdata
);

  localparam int DEPTH = 1 << LINE_IX_BITS;

  entry_t mem [DEPTH];
  logic sweeping;
  logic [LINE_IX_BITS-1:0] sweep_ix;

  // one entry cleared per cycle until the last index is done
  always_ff @(posedge clk) begin
    if (rst) begin
      sweeping <= 1'b1;
      sweep_ix <= '0;
    end else if (sweeping) begin
      mem[sweep_ix] <= '0;
      sweep_ix <= sweep_ix + 1'b1;
      if (&sweep_ix) begin
        sweeping <= 1'b0;
      end
    end else if (we) begin
      mem[index] <= wdata;
    end
  end

  // entries read as cleared while the sweep is still running
  assign rdata = sweeping ? entry_t'('0) : mem[index];

  // the lookup and the controller must hold off until the array is clean
  a_no_write_in_sweep: assert property (@(posedge clk) disable iff (rst) sweeping |-> !we)
    else $error("cache_ram: write during reset sweep");

endmodule

`default_nettype wire

//--- design/cache_lookup.sv
// ---------------------------------------
// cache lookup
// address split, hit check, word select
// and byte-strobed write-hit merge
// ---------------------------------------

`timescale 1ns/1ps
`default_nettype none

module cache_lookup import cache_pkg::*; #(
  parameter int LINE_IX_BITS = 8
) (
  input wire cpu_req_t req,
  input wire tag_entry_t tag_rd,
  input wire line_t line_rd,
  input wire fill_active,
  output logic [LINE_IX_BITS-1:0] index,
  output logic hit,
  output word_t data_out,
  output logic data_ready,
  output logic busy,
  output logic tag_we,
  output tag_entry_t tag_wr,
  output logic line_we,
  output line_t line_wr
);

  localparam int IX_LO = OFFSET_BITS + COL_BITS;
  localparam int STROBES = WORD_BITS / 8;

  logic [COL_BITS-1:0] col;
  logic [LINE_ADDR_BITS-1:0] line_addr;
  logic is_write;
  logic write_hit;

  // |line address|col|offset|, the index is the low part of the line address
  assign col = req.addr[OFFSET_BITS +: COL_BITS];
  assign index = req.addr[IX_LO +: LINE_IX_BITS];
  assign line_addr = req.addr[WORD_BITS-1 -: LINE_ADDR_BITS];
  assign is_write = |req.strobe;

  assign hit = tag_rd.valid && (tag_rd.line_addr == line_addr);

  // word select from the async array read
  assign data_out = line_rd[col];

  // busy also covers the return cycle of a fill, when the tag already matches
  assign busy = !hit || fill_active;
  assign data_ready = hit && !is_write && !fill_active;

  // the fill owns both write ports while it runs
  assign write_hit = hit && is_write && !fill_active;
  assign tag_we = write_hit;
  assign line_we = write_hit;

  // write data stays zero when idle, the top level ORs it with the fill data
  always_comb begin
    tag_wr = '0;
    line_wr = '0;
    if (write_hit) begin
      tag_wr.valid = 1'b1;
      tag_wr.dirty = 1'b1;
      tag_wr.line_addr = line_addr;
      line_wr = line_rd;
      // only the enabled bytes of the addressed word change
      for (int b = 0; b < STROBES; b++) begin
        if (req.strobe[b]) begin
          line_wr[col][8*b +: 8] = req.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/burst_ctrl.sv
// ---------------------------------------
// burst controller
// evicts dirty lines and fills missed
// lines over the burst RAM port
// ---------------------------------------

`timescale 1ns/1ps
`default_nettype none

module burst_ctrl import cache_pkg::*; #(
  parameter int LINE_IX_BITS = 8
) (
  input wire clk,
  input wire rst,
  input wire word_t req_addr,
  input wire is_write,
  input wire hit,
  input wire tag_entry_t tag_rd,
  input wire line_t line_rd,
  output logic fill_active,
  output logic fill_tag_we,
  output tag_entry_t fill_tag,
  output logic fill_line_we,
  output line_t fill_line,
  output br_req_t br_req,
  input wire br_rsp_t br_rsp
);

  localparam int BEAT_IX_BITS = $clog2(BEATS);
  localparam logic [BEAT_IX_BITS-1:0] LAST_BEAT = BEAT_IX_BITS'(BEATS - 1);

  // one-hot state encoding
  localparam logic [5:0] ST_IDLE = 6'b00_0001;
  localparam logic [5:0] ST_EVICT = 6'b00_0010;
  localparam logic [5:0] ST_FILL_WAIT = 6'b00_0100;
  localparam logic [5:0] ST_FILL_BEATS = 6'b00_1000;
  localparam logic [5:0] ST_COMMIT = 6'b01_0000;
  localparam logic [5:0] ST_FINISH = 6'b10_0000;

  logic [5:0] state;
  logic [BEAT_IX_BITS-1:0] beat_ix;
  logic rd_issued;
  logic [LINE_ADDR_BITS-1:0] req_line;
  logic [BEATS-1:0][BEAT_BITS-1:0] victim;
  logic [BEATS-1:0][BEAT_BITS-1:0] beat_buf;
  logic [LINE_IX_BITS:0] clear_cnt;
  logic clear_done;

  assign req_line = req_addr[WORD_BITS-1 -: LINE_ADDR_BITS];
  // same bit layout as line_t, viewed as beats
  assign victim = line_rd;

  // no command until the arrays have swept every line after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      clear_cnt <= '0;
    end else if (!clear_done) begin
      clear_cnt <= clear_cnt + 1'b1;
    end
  end

  assign clear_done = clear_cnt[LINE_IX_BITS];

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      br_req.cmd_en <= 1'b0;
      rd_issued <= 1'b0;
      beat_ix <= '0;
    end else begin
      // cmd_en is a single-cycle pulse
      br_req.cmd_en <= 1'b0;
      unique case (state)
        ST_IDLE: begin
          if (!hit && !br_rsp.busy && clear_done) begin
            br_req.cmd_en <= 1'b1;
            if (tag_rd.valid && tag_rd.dirty) begin
              // write back the victim, beat 0 goes with the command
              br_req.write <= 1'b1;
              br_req.addr <= {tag_rd.line_addr, {BEAT_IX_BITS{1'b0}}};
              br_req.wdata <= victim[0];
              beat_ix <= 1;
              rd_issued <= 1'b0;
              state <= ST_EVICT;
            end else begin
              br_req.write <= 1'b0;
              br_req.addr <= {req_line, {BEAT_IX_BITS{1'b0}}};
              rd_issued <= 1'b1;
              state <= ST_FILL_WAIT;
            end
          end
        end
        ST_EVICT: begin
          // beat_ix wraps to zero once the last beat is on the bus
          if (beat_ix != '0) begin
            br_req.wdata <= victim[beat_ix];
            beat_ix <= beat_ix + 1'b1;
          end else begin
            state <= ST_FILL_WAIT;
          end
        end
        ST_FILL_WAIT: begin
          if (!rd_issued) begin
            // read command after an eviction
            if (!br_rsp.busy) begin
              br_req.cmd_en <= 1'b1;
              br_req.write <= 1'b0;
              br_req.addr <= {req_line, {BEAT_IX_BITS{1'b0}}};
              rd_issued <= 1'b1;
            end
          end else if (br_rsp.rd_data_ready) begin
            beat_buf[0] <= br_rsp.rdata;
            beat_ix <= 1;
            state <= ST_FILL_BEATS;
          end
        end
        ST_FILL_BEATS: begin
          beat_buf[beat_ix] <= br_rsp.rdata;
          beat_ix <= beat_ix + 1'b1;
          if (beat_ix == LAST_BEAT) begin
            state <= ST_COMMIT;
          end
        end
        ST_COMMIT: begin
          state <= ST_FINISH;
        end
        ST_FINISH: begin
          rd_issued <= 1'b0;
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // held high through the return cycle so the lookup keeps its ports idle
  assign fill_active = (state != ST_IDLE);

  assign fill_tag_we = (state == ST_COMMIT);
  assign fill_line_we = (state == ST_COMMIT);

  // zero outside commit, merged with the lookup ports by OR
  always_comb begin
    fill_tag = '0;
    fill_line = '0;
    if (state == ST_COMMIT) begin
      fill_tag.valid = 1'b1;
      fill_tag.line_addr = req_line;
      fill_line = beat_buf;
    end
  end

  // the read burst arrives without gaps after its first beat
  a_burst_no_gap: assert property (@(posedge clk) disable iff (rst)
    (state == ST_FILL_WAIT && rd_issued && br_rsp.rd_data_ready)
      |=> br_rsp.rd_data_ready [* (BEATS - 1)])
    else $error("burst_ctrl: gap in read burst");

  // a fill write never meets a write hit on the shared array ports
  a_one_writer: assert property (@(posedge clk) disable iff (rst)
    (fill_tag_we || fill_line_we) |-> !(hit && is_write))
    else $error("burst_ctrl: fill write overlaps write hit");

  // the tag array is read at the index of the pending request
  a_victim_index: assert property (@(posedge clk) disable iff (rst)
    (state == ST_IDLE && tag_rd.valid)
      |-> tag_rd.line_addr[LINE_IX_BITS-1:0] == req_line[LINE_IX_BITS-1:0])
    else $error("burst_ctrl: tag read at wrong index");

endmodule

`default_nettype wire

//--- design/cache_top.sv
// ---------------------------------------
// write-back data cache top level
// joins lookup, burst controller and the
// tag and data arrays
// ---------------------------------------

`timescale 1ns/1ps
`default_nettype none

module cache_top import cache_pkg::*; #(
  parameter int LINE_IX_BITS = 8
) (
  input wire clk,
  input wire rst,
  input wire cpu_req_t req,
  output word_t data_out,
  output logic data_ready,
  output logic busy,
  output br_req_t br_req,
  input wire br_rsp_t br_rsp
);

  logic [LINE_IX_BITS-1:0] index;
  logic hit;
  logic fill_active;

  tag_entry_t tag_rd;
  tag_entry_t look_tag_wr;
  tag_entry_t fill_tag;
  tag_entry_t tag_wdata;
  logic look_tag_we;
  logic fill_tag_we;

  line_t line_rd;
  line_t look_line_wr;
  line_t fill_line;
  line_t line_wdata;
  logic look_line_we;
  logic fill_line_we;

  cache_lookup #(
    .LINE_IX_BITS(LINE_IX_BITS)
  ) lookup (
    .req(req),
    .tag_rd(tag_rd),
    .line_rd(line_rd),
    .fill_active(fill_active),
    .index(index),
    .hit(hit),
    .data_out(data_out),
    .data_ready(data_ready),
    .busy(busy),
    .tag_we(look_tag_we),
    .tag_wr(look_tag_wr),
    .line_we(look_line_we),
    .line_wr(look_line_wr)
  );

  burst_ctrl #(
    .LINE_IX_BITS(LINE_IX_BITS)
  ) ctrl (
    .clk(clk),
    .rst(rst),
    .req_addr(req.addr),
    .is_write(|req.strobe),
    .hit(hit),
    .tag_rd(tag_rd),
    .line_rd(line_rd),
    .fill_active(fill_active),
    .fill_tag_we(fill_tag_we),
    .fill_tag(fill_tag),
    .fill_line_we(fill_line_we),
    .fill_line(fill_line),
    .br_req(br_req),
    .br_rsp(br_rsp)
  );

  // each side drives zeros when idle, so OR merges the single write port
  assign tag_wdata = look_tag_wr | fill_tag;
  assign line_wdata = look_line_wr | fill_line;

  cache_ram #(
    .LINE_IX_BITS(LINE_IX_BITS),
    .entry_t(tag_entry_t)
  ) tag_store (
    .clk(clk),
    .rst(rst),
    .index(index),
    .we(look_tag_we | fill_tag_we),
    .wdata(tag_wdata),
    .rdata(tag_rd)
  );

  cache_ram #(
    .LINE_IX_BITS(LINE_IX_BITS),
    .entry_t(line_t)
  ) data_store (
    .clk(clk),
    .rst(rst),
    .index(index),
    .we(look_line_we | fill_line_we),
    .wdata(line_wdata),
    .rdata(line_rd)
  );

endmodule

`default_nettype wire

//--- dv/burst_ram_model.sv
// ---------------------------------------
// burst RAM model
// four-beat bursts, fixed read latency,
// words preset from their byte address
// ---------------------------------------

`timescale 1ns/1ps
`default_nettype none

module burst_ram_model import cache_pkg::*; #(
  parameter int RAM_ADDR_BITS = 10,
  parameter int READ_LATENCY = 3
) (
  input wire clk,
  input wire rst,
  input wire br_req_t br_req,
  output br_rsp_t br_rsp
);

  localparam int DEPTH = 1 << RAM_ADDR_BITS;
  localparam int BEAT_IX_BITS = $clog2(BEATS);

  beat_t mem [DEPTH];
  logic [RAM_ADDR_BITS-1:BEAT_IX_BITS] line;
  logic [BEAT_IX_BITS-1:0] beat_ix;
  logic writing;
  logic reading;
  int wait_cnt;

  // each word holds its own byte address XOR a fixed pattern
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = {32'(i * 8 + 4) ^ 32'hA5A5_0000, 32'(i * 8) ^ 32'hA5A5_0000};
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      br_rsp <= '0;
      writing <= 1'b0;
      reading <= 1'b0;
      wait_cnt <= 0;
      beat_ix <= '0;
    end else if (br_req.cmd_en) begin
      br_rsp.busy <= 1'b1;
      line <= br_req.addr[RAM_ADDR_BITS-1:BEAT_IX_BITS];
      if (br_req.write) begin
        // beat 0 comes with the command
        mem[br_req.addr[RAM_ADDR_BITS-1:0]] <= br_req.wdata;
        beat_ix <= 1;
        writing <= 1'b1;
      end else begin
        wait_cnt <= READ_LATENCY;
        beat_ix <= '0;
        reading <= 1'b1;
      end
    end else if (writing) begin
      mem[{line, beat_ix}] <= br_req.wdata;
      beat_ix <= beat_ix + 1'b1;
      if (&beat_ix) begin
        writing <= 1'b0;
        br_rsp.busy <= 1'b0;
      end
    end else if (reading) begin
      if (wait_cnt > 1) begin
        wait_cnt <= wait_cnt - 1;
      end else if (wait_cnt == 1) begin
        wait_cnt <= 0;
        br_rsp.rd_data_ready <= 1'b1;
        br_rsp.rdata <= mem[{line, beat_ix}];
        beat_ix <= 1;
      end else if (beat_ix != '0) begin
        // beats 1 to 3 back to back, index wraps after the last
        br_rsp.rdata <= mem[{line, beat_ix}];
        beat_ix <= beat_ix + 1'b1;
      end else begin
        br_rsp.rd_data_ready <= 1'b0;
        br_rsp.busy <= 1'b0;
        reading <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/tb_cache.sv
// ---------------------------------------
// cache testbench
// table of reads and writes checked
// against a shadow memory
// ---------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_cache import cache_pkg::*; ();

  localparam int LINE_IX_BITS = 2;
  localparam int TIMEOUT = 200;
  localparam int SEED = 27906;
  localparam word_t PATTERN = 32'hA5A5_0000;

  typedef struct packed {
    logic is_write;
    word_t addr;
    word_t wdata;
    strobe_t strobe;
    logic exp_hit;
    logic [1:0] exp_cmds;
    logic check_evict;
    word_t victim;
  } entry_t;

  logic clk;
  logic rst;
  cpu_req_t req;
  word_t data_out;
  logic data_ready;
  logic busy;
  br_req_t br_req;
  br_rsp_t br_rsp;

  entry_t stim_q[$];
  word_t shadow [word_t];
  int cmd_count = 0;
  int wr_bursts = 0;
  int wr_ix = 0;
  logic wr_capture = 1'b0;
  beat_t wr_beats [BEATS];
  logic [BEAT_ADDR_BITS-1:0] wr_addr;
  int passed = 0;
  int failed = 0;
  int entry_errs = 0;
  logic timed_out = 1'b0;

  cache_top #(
    .LINE_IX_BITS(LINE_IX_BITS)
  ) uut (
    .clk(clk),
    .rst(rst),
    .req(req),
    .data_out(data_out),
    .data_ready(data_ready),
    .busy(busy),
    .br_req(br_req),
    .br_rsp(br_rsp)
  );

  burst_ram_model #(
    .RAM_ADDR_BITS(10),
    .READ_LATENCY(3)
  ) ram (
    .clk(clk),
    .rst(rst),
    .br_req(br_req),
    .br_rsp(br_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // bus monitor, counts commands and captures write bursts
  always @(negedge clk) begin
    if (br_req.cmd_en === 1'b1) begin
      cmd_count++;
      if (br_req.write) begin
        wr_bursts++;
        wr_addr = br_req.addr;
        wr_beats[0] = br_req.wdata;
        wr_ix = 1;
        wr_capture = 1'b1;
      end
    end else if (wr_capture) begin
      wr_beats[wr_ix] = br_req.wdata;
      wr_ix++;
      if (wr_ix == BEATS) begin
        wr_capture = 1'b0;
      end
    end
  end

  function automatic word_t shadow_read(word_t addr);
    word_t a;
    a = {addr[WORD_BITS-1:2], 2'b00};
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return a ^ PATTERN;
  endfunction

  function automatic void shadow_write(word_t addr, word_t data, strobe_t strobe);
    word_t w;
    w = shadow_read(addr);
    for (int b = 0; b < WORD_BITS / 8; b++) begin
      if (strobe[b]) begin
        w[8*b +: 8] = data[8*b +: 8];
      end
    end
    shadow[{addr[WORD_BITS-1:2], 2'b00}] = w;
  endfunction

  task automatic add_entry(input logic is_write, input word_t addr, input word_t wdata,
                           input strobe_t strobe, input logic exp_hit, input int exp_cmds,
                           input logic check_evict, input word_t victim);
    entry_t e;
    e.is_write = is_write;
    e.addr = addr;
    e.wdata = wdata;
    e.strobe = strobe;
    e.exp_hit = exp_hit;
    e.exp_cmds = 2'(exp_cmds);
    e.check_evict = check_evict;
    e.victim = victim;
    stim_q.push_back(e);
  endtask

  task automatic flag_error(input string test, input string msg);
    $display("FAIL @%0t: %s: %s", $time, test, msg);
    entry_errs++;
  endtask

  // drives one entry at the current falling edge and checks the answer
  task automatic run_entry(input int idx);
    entry_t e;
    string name;
    int cycles;
    int cmds0;
    int bursts0;
    word_t exp_word;
    beat_t exp_beat;
    e = stim_q[idx];
    name = $sformatf("entry %0d", idx);
    cycles = 0;
    entry_errs = 0;
    req.addr = e.addr;
    req.wdata = e.wdata;
    req.strobe = e.strobe;
    #1;
    // a command seen at this edge belongs to the previous request
    cmds0 = cmd_count;
    bursts0 = wr_bursts;
    while (busy !== 1'b0 && cycles < TIMEOUT) begin
      @(negedge clk);
      #1;
      cycles++;
    end
    if (busy !== 1'b0) begin
      $display("%s: busy stayed high for %0d cycles, the cache never answered", name, TIMEOUT);
      timed_out = 1'b1;
      entry_errs++;
    end else begin
      if (e.exp_hit && cycles != 0) begin
        flag_error(name, $sformatf("expected a hit, busy was high %0d cycles", cycles));
      end
      if (!e.exp_hit && cycles == 0) begin
        flag_error(name, "expected a miss, busy was low at once");
      end
      if (e.is_write) begin
        if (data_ready !== 1'b0) begin
          flag_error(name, "data_ready high on a write");
        end
        shadow_write(e.addr, e.wdata, e.strobe);
      end else begin
        exp_word = shadow_read(e.addr);
        if (data_ready !== 1'b1) begin
          flag_error(name, "data_ready low on a read");
        end
        if (data_out !== exp_word) begin
          flag_error(name, $sformatf("data_out 0x%08h, expected 0x%08h", data_out, exp_word));
        end
      end
      if (e.check_evict) begin
        if (wr_bursts - bursts0 != 1) begin
          flag_error(name, $sformatf("%0d write bursts, expected 1", wr_bursts - bursts0));
        end else begin
          if (wr_addr != BEAT_ADDR_BITS'(e.victim >> 3)) begin
            flag_error(name, $sformatf("write burst at beat 0x%0h", wr_addr));
          end
          for (int k = 0; k < BEATS; k++) begin
            exp_beat = {shadow_read(e.victim + 32'(8 * k + 4)),
                        shadow_read(e.victim + 32'(8 * k))};
            if (wr_beats[k] !== exp_beat) begin
              flag_error(name, $sformatf("evict beat %0d 0x%016h, expected 0x%016h",
                                         k, wr_beats[k], exp_beat));
            end
          end
        end
      end
      // a write hit commits at the next rising edge
      @(negedge clk);
      #1;
      // a stray command from this request shows up by now
      if (cmd_count - cmds0 != int'(e.exp_cmds)) begin
        flag_error(name, $sformatf("%0d burst commands, expected %0d",
                                   cmd_count - cmds0, e.exp_cmds));
      end
      @(negedge clk);
    end
    if (entry_errs == 0) begin
      passed++;
      $display("ok   %s %s 0x%08h after %0d cycles", name, e.is_write ? "write" : "read ",
               e.addr, cycles);
    end else begin
      failed++;
      $display("%s finished with %0d errors", name, entry_errs);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    rst = 1'b1;
    req = '0;

    // index 2: fill, hits, strobed writes, then a conflict that evicts
    add_entry(1'b0, 32'h0000_0040, '0, 4'b0000, 1'b0, 1, 1'b0, '0);
    add_entry(1'b0, 32'h0000_005C, '0, 4'b0000, 1'b1, 0, 1'b0, '0);
    add_entry(1'b0, 32'h0000_0044, '0, 4'b0000, 1'b1, 0, 1'b0, '0);
    add_entry(1'b1, 32'h0000_0048, 32'h1122_3344, 4'b0101, 1'b1, 0, 1'b0, '0);
    add_entry(1'b0, 32'h0000_0048, '0, 4'b0000, 1'b1, 0, 1'b0, '0);
    add_entry(1'b1, 32'h0000_004C, $urandom(), 4'b1111, 1'b1, 0, 1'b0, '0);
    add_entry(1'b0, 32'h0000_00C0, '0, 4'b0000, 1'b0, 2, 1'b1, 32'h0000_0040);
    add_entry(1'b0, 32'h0000_00C4, '0, 4'b0000, 1'b1, 0, 1'b0, '0);
    add_entry(1'b0, 32'h0000_0048, '0, 4'b0000, 1'b0, 1, 1'b0, '0);
    add_entry(1'b0, 32'h0000_004C, '0, 4'b0000, 1'b1, 0, 1'b0, '0);
    // index 3 clean, then a write miss replaces it
    add_entry(1'b0, 32'h0000_0060, '0, 4'b0000, 1'b0, 1, 1'b0, '0);
    add_entry(1'b1, 32'h0000_00E8, $urandom(), 4'b0011, 1'b0, 1, 1'b0, '0);
    add_entry(1'b0, 32'h0000_00E8, '0, 4'b0000, 1'b1, 0, 1'b0, '0);
    add_entry(1'b0, 32'h0000_00E0, '0, 4'b0000, 1'b1, 0, 1'b0, '0);
    // write miss to an empty line
    add_entry(1'b1, 32'h0000_01A0, $urandom(), 4'b1111, 1'b0, 1, 1'b0, '0);
    add_entry(1'b0, 32'h0000_01A0, '0, 4'b0000, 1'b1, 0, 1'b0, '0);

    entry_errs = 0;
    repeat (2) begin
      @(negedge clk);
      if (br_req.cmd_en !== 1'b0) begin
        flag_error("reset", "cmd_en not low during reset");
      end
    end
    if (entry_errs == 0) begin
      passed++;
      $display("ok   reset cmd_en low");
    end else begin
      failed++;
      $display("reset finished with %0d errors", entry_errs);
    end

    // first request goes out with the reset release
    rst = 1'b0;
    for (int i = 0; i < stim_q.size(); i++) begin
      if (!timed_out) begin
        run_entry(i);
      end
    end

    $display("tests: %0d passed, %0d failed", passed, failed);
    if (failed == 0 && !timed_out) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- cache_top.f
design/cache_pkg.sv
design/cache_ram.sv
design/cache_lookup.sv
design/burst_ctrl.sv
design/cache_top.sv
dv/burst_ram_model.sv
dv/tb_cache.sv

//--- Makefile
# Verilator build and run for the write-back cache testbench

VERILATOR ?= verilator
TOP ?= tb_cache
FILELIST ?= cache_top.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "=== PASS ===" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
